/* project.f */
+incdir+logic
logic/arcade_pkg.sv
logic/rom_dl_if.sv
logic/rom_loader.sv
logic/reset_sequencer.sv
logic/control_mapper.sv
logic/sigma_delta_dac.sv
logic/mist_arcade_shell.sv
sim/shell_properties.sv
sim/tb_mist_arcade_shell.sv

/* Bender.yml */
package:
  name: mist_arcade_shell

sources:
  - include_dirs:
      - logic
    files:
      - logic/arcade_pkg.sv
      - logic/rom_dl_if.sv
      - logic/rom_loader.sv
      - logic/reset_sequencer.sv
      - logic/control_mapper.sv
      - logic/sigma_delta_dac.sv
      - logic/mist_arcade_shell.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/shell_properties.sv
      - sim/tb_mist_arcade_shell.sv

/* sim/tb_mist_arcade_shell.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module tb_mist_arcade_shell;
	import arcade_pkg::*;

	// DAC windows need 4 x 4096 cycles and the other tests well under 1000
	localparam int MAX_CYCLES = 20000;

	logic        clk_sys;
	logic        rst_n_i;
	logic [31:0] status_i;
	logic [1:0]  buttons_i;
	logic [6:0]  core_mod_i;
	logic        ioctl_download_i;
	logic [7:0]  ioctl_index_i;
	logic        ioctl_wr_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0]  ioctl_dout_i;
	logic [7:0]  joystick_0_i;
	logic [7:0]  joystick_1_i;
	logic        snd_vma_i;
	logic [15:0] snd_rom_addr_i;
	logic [11:0] audio_i;
	logic        port1_req_o;
	sdram_wr_t   port1_o;
	logic        port2_req_o;
	sdram_wr_t   port2_o;
	logic        port_we_o;
	logic [17:0] snd_addr_o;
	logic        core_reset_o;
	logic        led_o;
	player_t     player1_o;
	player_t     player2_o;
	cabinet_t    cabinet_o;
	logic [7:0]  dsw_o;
	orient_t     orient_o;
	logic        audio_o;

	int          errors = 0;
	int          checks = 0;
	int          err_mark = 0;
	int          cycle_cnt = 0;
	string       test_name;
	logic [31:0] rng_state = 32'hd08a8d86;

	mist_arcade_shell u_mist_arcade_shell (.*);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return {rng_state[15:0], rng_state[31:16]}; // Low LCG bits are weak
	endfunction

	// Inputs move 2 ns after the edge so registered outputs have settled
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_logic(input string label, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s/%s: expected %h, actual %h", test_name, label, exp, act);
		end
	endtask

	task automatic check_player(input string label, input player_t exp, input player_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s/%s: expected %b, actual %b", test_name, label, exp, act);
		end
	endtask

	task automatic check_cabinet(input string label, input cabinet_t exp, input cabinet_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s/%s: expected %b, actual %b", test_name, label, exp, act);
		end
	endtask

	task automatic check_port(input string label, input sdram_wr_t exp, input sdram_wr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s/%s: expected %h, actual %h", test_name, label, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_mark = errors;
	endtask

	task automatic end_test();
		$display("Test %s finished with %0d errors", test_name, errors - err_mark);
	endtask

	function automatic sdram_wr_t expected_port(input logic [24:0] byte_addr,
		input logic [7:0] data);
		sdram_wr_t w;
		w.addr = byte_addr[23:1];
		w.ds   = byte_addr[0] ? 2'b10 : 2'b01; // Odd byte in the upper lane
		w.data = {2{data}};
		return w;
	endfunction

	function automatic orient_t expected_orient(input logic [6:0] mode);
		case (mode)
			7'd6:    return 2'b11;
			7'd11:   return 2'b01;
			default: return 2'b10;
		endcase
	endfunction

	function automatic player_t expected_player(input logic [7:0] joy, input logic rot);
		player_t p;
		p.fire_a = joy[4];
		p.fire_b = joy[5];
		p.up     = rot ? joy[0] : joy[3];
		p.right  = rot ? joy[2] : joy[0];
		p.down   = rot ? joy[1] : joy[2];
		p.left   = rot ? joy[3] : joy[1];
		return p;
	endfunction

	task automatic expect_reset_fall(input string label, input int fall_edge);
		for (int i = 1; i <= fall_edge; i++) begin
			next_cycle();
			check_logic(label, i < fall_edge, core_reset_o);
		end
	endtask

	task automatic test_download();
		logic [24:0] addr;
		logic [7:0]  data;
		logic        upper;
		logic        exp_req1;
		logic        exp_req2;
		begin_test("download_bursts");
		exp_req1 = 1'b0;
		exp_req2 = 1'b0;
		check_logic("reset_before_load", 1'b1, core_reset_o);
		check_logic("led_idle", 1'b1, led_o);
		check_logic("we_idle", 1'b0, port_we_o);
		ioctl_download_i = 1'b1;
		next_cycle();
		for (int i = 0; i < 24; i++) begin
			if (i[0])
				addr = `CORE_SPR_BASE + 25'(next_rand() % 32'h10000);
			else
				addr = 25'(next_rand() % `CORE_SPR_BASE);
			if (i == 1)
				addr = `CORE_SPR_BASE; // Exactly on the boundary
			data = 8'(next_rand());
			upper = addr >= `CORE_SPR_BASE;
			ioctl_addr_i = addr;
			ioctl_dout_i = data;
			ioctl_wr_i   = 1'b1;
			#5;
			check_logic("port_we", 1'b1, port_we_o);
			check_port("port1", expected_port(addr, data), port1_o);
			if (upper)
				check_port("port2", expected_port(addr - `CORE_SPR_BASE, data), port2_o);
			next_cycle();
			exp_req1 = ~exp_req1;
			if (upper)
				exp_req2 = ~exp_req2;
			check_logic("port1_req", exp_req1, port1_req_o);
			check_logic("port2_req", exp_req2, port2_req_o);
			check_logic("led_busy", 1'b0, led_o);
			check_logic("reset_in_load", 1'b1, core_reset_o);
			ioctl_wr_i = 1'b0;
			next_cycle();
		end
		ioctl_download_i = 1'b0;
	endtask

	task automatic test_reset();
		begin_test("reset_sequence");
		// Loaded flag lands on the first edge after download drops
		expect_reset_fall("after_load", `CORE_RESET_HOLD + 1);
		check_logic("led_idle", 1'b1, led_o);
		check_logic("we_idle", 1'b0, port_we_o);
		status_i[0] = 1'b1;
		next_cycle();
		check_logic("status_raise", 1'b1, core_reset_o);
		next_cycle();
		status_i[0] = 1'b0;
		// Edge just before the release is the last one with a cause
		expect_reset_fall("status_release", `CORE_RESET_HOLD);
		buttons_i[1] = 1'b1;
		next_cycle();
		check_logic("button_raise", 1'b1, core_reset_o);
		next_cycle();
		buttons_i[1] = 1'b0;
		expect_reset_fall("button_release", `CORE_RESET_HOLD);
	endtask

	task automatic test_sound();
		logic [15:0] addr;
		logic [17:0] old_val;
		logic [17:0] exp_val;
		begin_test("sound_reloc");
		old_val = 18'd0; // Cleared by reset
		for (int n = 0; n < 3; n++) begin
			addr = 16'(next_rand());
			exp_val = {2'b00, addr} + `CORE_SND_BASE;
			snd_rom_addr_i = addr;
			snd_vma_i = 1'b1;
			for (int e = 1; e <= 3; e++) begin
				next_cycle();
				snd_vma_i = 1'b0; // One cycle pulse
				check_logic("snd_addr", (e < 3) ? old_val : exp_val, snd_addr_o);
			end
			for (int e = 0; e < 4; e++) begin
				snd_rom_addr_i = 16'(next_rand());
				next_cycle();
				check_logic("snd_hold", exp_val, snd_addr_o);
			end
			old_val = exp_val;
		end
	endtask

	task automatic test_profiles();
		logic [6:0] modes [4] = '{7'd0, 7'd3, 7'd6, 7'd11};
		logic       one_player;
		begin_test("profiles");
		foreach (modes[m]) begin
			core_mod_i   = modes[m];
			status_i     = next_rand() & ~32'h45; // No rotate, no swap, no reset
			joystick_0_i = 8'(next_rand());
			joystick_1_i = ~joystick_0_i;
			one_player   = modes[m] != 7'd3;
			#5;
			check_logic("orient", expected_orient(modes[m]), orient_o);
			check_player("player2",
				expected_player(one_player ? joystick_0_i : joystick_1_i, 1'b0), player2_o);
			check_logic("dsw", {4'hf, ~status_i[11:8]}, dsw_o);
			next_cycle();
		end
	endtask

	task automatic test_controls();
		logic [7:0] sa;
		logic [7:0] sb;
		logic       rot_eff;
		logic       one_player;
		orient_t    orient;
		cabinet_t   exp_cab;
		begin_test("controls");
		for (int mi = 0; mi < 2; mi++) begin
			core_mod_i = mi ? 7'd3 : 7'd6;
			one_player = core_mod_i != 7'd3;
			orient = expected_orient(core_mod_i);
			for (int combo = 0; combo < 4; combo++) begin
				for (int n = 0; n < 6; n++) begin
					status_i = next_rand() & ~32'h45;
					status_i[2] = combo[0];
					status_i[6] = combo[1];
					joystick_0_i = 8'(next_rand());
					joystick_1_i = 8'(next_rand());
					#5;
					sa = status_i[6] ? joystick_1_i : joystick_0_i;
					sb = status_i[6] ? joystick_0_i : joystick_1_i;
					rot_eff = status_i[2] && orient[0];
					exp_cab.coin1   = sa[6];
					exp_cab.coin2   = sb[6];
					exp_cab.start1  = sa[7];
					exp_cab.start2  = sb[7];
					exp_cab.service = status_i[7];
					check_player("player1", expected_player(sa, rot_eff), player1_o);
					check_player("player2",
						expected_player(one_player ? sa : sb, rot_eff), player2_o);
					check_cabinet("cabinet", exp_cab, cabinet_o);
					next_cycle();
				end
			end
		end
	endtask

	task automatic test_dac();
		logic [11:0] samples [4] = '{12'd0, 12'd1, 12'd1234, 12'd4095};
		int          ones;
		begin_test("dac_density");
		foreach (samples[s]) begin
			audio_i = samples[s];
			ones = 0;
			repeat (4096) begin
				next_cycle();
				ones += audio_o;
			end
			check_logic("ones", samples[s], ones);
		end
	endtask

	initial begin
		rst_n_i          = 1'b0;
		status_i         = '0;
		buttons_i        = '0;
		core_mod_i       = '0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		joystick_0_i     = '0;
		joystick_1_i     = '0;
		snd_vma_i        = 1'b0;
		snd_rom_addr_i   = '0;
		audio_i          = '0;
		repeat (2) @(posedge clk_sys);
		#2;
		rst_n_i = 1'b1;
		test_download();
		end_test();
		test_reset();
		end_test();
		test_sound();
		end_test();
		test_profiles();
		end_test();
		test_controls();
		end_test();
		test_dac();
		end_test();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* sim/shell_properties.sv */
`timescale 1ns/1ns

module shell_properties (
	input logic clk_sys,
	input logic rst_n_i,
	input logic download_i,
	input logic req1_i,
	input logic req2_i,
	input logic core_reset_i
);

	// Toggle shows one edge after the write seen in download
	req1_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		$changed(req1_i) |-> $past(download_i))
		else $error("port1 request toggled outside a download");

	req2_with_req1: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		$changed(req2_i) |-> $changed(req1_i))
		else $error("port2 request toggled without port1");

	reset_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		download_i |-> core_reset_i)
		else $error("core reset low while a download runs");

endmodule

bind mist_arcade_shell shell_properties u_shell_properties (
	.clk_sys      (clk_sys),
	.rst_n_i      (rst_n_i),
	.download_i   (ioctl_download_i),
	.req1_i       (port1_req_o),
	.req2_i       (port2_req_o),
	.core_reset_i (core_reset_o)
);

/* logic/mist_arcade_shell.sv */
`timescale 1ns/1ns

module mist_arcade_shell (
	input  logic                  clk_sys,
	input  logic                  rst_n_i,
	input  logic [31:0]           status_i,
	input  logic [1:0]            buttons_i,
	input  logic [6:0]            core_mod_i,
	input  logic                  ioctl_download_i,
	input  logic [7:0]            ioctl_index_i,
	input  logic                  ioctl_wr_i,
	input  logic [24:0]           ioctl_addr_i,
	input  logic [7:0]            ioctl_dout_i,
	input  logic [7:0]            joystick_0_i,
	input  logic [7:0]            joystick_1_i,
	input  logic                  snd_vma_i,
	input  logic [15:0]           snd_rom_addr_i,
	input  logic [11:0]           audio_i,
	output logic                  port1_req_o,
	output arcade_pkg::sdram_wr_t port1_o,
	output logic                  port2_req_o,
	output arcade_pkg::sdram_wr_t port2_o,
	output logic                  port_we_o,
	output logic [17:0]           snd_addr_o,
	output logic                  core_reset_o,
	output logic                  led_o,
	output arcade_pkg::player_t   player1_o,
	output arcade_pkg::player_t   player2_o,
	output arcade_pkg::cabinet_t  cabinet_o,
	output logic [7:0]            dsw_o,
	output arcade_pkg::orient_t   orient_o,
	output logic                  audio_o
);

	rom_dl_if u_dl ();

	assign u_dl.download = ioctl_download_i;
	assign u_dl.index    = ioctl_index_i;
	assign u_dl.wr       = ioctl_wr_i;
	assign u_dl.addr     = ioctl_addr_i;
	assign u_dl.dout     = ioctl_dout_i;

	rom_loader u_rom_loader (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.dl             (u_dl.sink),
		.snd_vma_i      (snd_vma_i),
		.snd_rom_addr_i (snd_rom_addr_i),
		.port1_req_o    (port1_req_o),
		.port1_o        (port1_o),
		.port2_req_o    (port2_req_o),
		.port2_o        (port2_o),
		.port_we_o      (port_we_o),
		.snd_addr_o     (snd_addr_o)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.dl             (u_dl.sink),
		.status_reset_i (status_i[0]),
		.button_reset_i (buttons_i[1]),
		.core_reset_o   (core_reset_o),
		.led_o          (led_o)
	);

	control_mapper u_control_mapper (
		.core_mod_i   (core_mod_i),
		.status_i     (status_i),
		.joystick_0_i (joystick_0_i),
		.joystick_1_i (joystick_1_i),
		.player1_o    (player1_o),
		.player2_o    (player2_o),
		.cabinet_o    (cabinet_o),
		.dsw_o        (dsw_o),
		.orient_o     (orient_o)
	);

	sigma_delta_dac #(
		.DAC_BITS (12)
	) u_dac (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.sample_i (audio_i),
		.dac_o    (audio_o)
	);

endmodule

/* logic/sigma_delta_dac.sv */
`timescale 1ns/1ns

module sigma_delta_dac #(
	parameter int DAC_BITS = 12
) (
	input  logic                clk_sys,
	input  logic                rst_n_i,
	input  logic [DAC_BITS-1:0] sample_i,
	output logic                dac_o
);
	logic [DAC_BITS-1:0] acc;
	logic [DAC_BITS:0]   sum;

	assign sum = {1'b0, acc} + {1'b0, sample_i};

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc   <= '0;
			dac_o <= 1'b0;
		end else begin
			acc   <= sum[DAC_BITS-1:0];
			dac_o <= sum[DAC_BITS]; // Carry is the pulse density
		end
	end

endmodule

/* logic/control_mapper.sv */
`timescale 1ns/1ns

module control_mapper (
	input  logic [6:0]           core_mod_i,
	input  logic [31:0]          status_i,
	input  logic [7:0]           joystick_0_i,
	input  logic [7:0]           joystick_1_i,
	output arcade_pkg::player_t  player1_o,
	output arcade_pkg::player_t  player2_o,
	output arcade_pkg::cabinet_t cabinet_o,
	output logic [7:0]           dsw_o,
	output arcade_pkg::orient_t  orient_o
);
	import arcade_pkg::*;

	logic       one_player;
	logic       rotate;
	logic [7:0] stick_a;
	logic [7:0] stick_b;

	// Stick bits are right, left, down, up, fire A, fire B, coin, start
	function automatic player_t map_stick(input logic [7:0] joy, input logic rot);
		player_t p;
		p.fire_b = joy[5];
		p.fire_a = joy[4];
		if (rot) begin
			p.up    = joy[0];
			p.right = joy[2];
			p.down  = joy[1];
			p.left  = joy[3];
		end else begin
			p.up    = joy[3];
			p.right = joy[0];
			p.down  = joy[2];
			p.left  = joy[1];
		end
		return p;
	endfunction

	// Per-game profile
	always_comb begin
		orient_o   = 2'b10;
		one_player = 1'b1;
		case (core_mod_i)
			7'h3: one_player = 1'b0;
			7'h6: orient_o = 2'b11;
			7'hB: orient_o = 2'b01;
			default: ;
		endcase
	end

	assign rotate  = status_i[2] && orient_o[0];
	assign stick_a = status_i[6] ? joystick_1_i : joystick_0_i;
	assign stick_b = status_i[6] ? joystick_0_i : joystick_1_i;

	assign player1_o = map_stick(stick_a, rotate);
	assign player2_o = map_stick(one_player ? stick_a : stick_b, rotate);

	assign cabinet_o.coin1   = stick_a[6];
	assign cabinet_o.coin2   = stick_b[6];
	assign cabinet_o.start1  = stick_a[7];
	assign cabinet_o.start2  = stick_b[7];
	assign cabinet_o.service = status_i[7];

	assign dsw_o = {4'hf, ~status_i[11:8]}; // Coinage fixed

endmodule

/* logic/reset_sequencer.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module reset_sequencer (
	input  logic   clk_sys,
	input  logic   rst_n_i,
	rom_dl_if.sink dl,
	input  logic   status_reset_i,
	input  logic   button_reset_i,
	output logic   core_reset_o,
	output logic   led_o
);
	logic        download_d;
	logic        rom_loaded;
	logic        cause;
	logic [15:0] hold_cnt;
	logic [15:0] hold_nxt;

	assign cause = status_reset_i || button_reset_i || !rom_loaded;

	always_comb begin
		if (cause)
			hold_nxt = `CORE_RESET_HOLD;
		else if (hold_cnt != 16'd0)
			hold_nxt = hold_cnt - 16'd1;
		else
			hold_nxt = 16'd0;
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			download_d   <= 1'b0;
			rom_loaded   <= 1'b0;
			hold_cnt     <= `CORE_RESET_HOLD;
			core_reset_o <= 1'b1;
		end else begin
			download_d <= dl.download;
			if (download_d && !dl.download)
				rom_loaded <= 1'b1; // End of the first transfer
			hold_cnt     <= hold_nxt;
			core_reset_o <= hold_nxt != 16'd0;
		end
	end

	assign led_o = ~dl.download; // Lit when idle

endmodule

/* logic/rom_loader.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module rom_loader (
	input  logic                  clk_sys,
	input  logic                  rst_n_i,
	rom_dl_if.sink                dl,
	input  logic                  snd_vma_i,
	input  logic [15:0]           snd_rom_addr_i,
	output logic                  port1_req_o,
	output arcade_pkg::sdram_wr_t port1_o,
	output logic                  port2_req_o,
	output arcade_pkg::sdram_wr_t port2_o,
	output logic                  port_we_o,
	output logic [17:0]           snd_addr_o
);
	logic        wr_last;
	logic        wr_rise;
	logic [24:0] spr_addr;
	logic        snd_vma_r;
	logic        snd_vma_r2;

	assign wr_rise  = dl.download && dl.wr && !wr_last;
	assign spr_addr = dl.addr - `CORE_SPR_BASE; // Port 2 starts at the sprite base

	// Byte lanes picked by the low address bit
	assign port1_o.addr = dl.addr[23:1];
	assign port1_o.ds   = {dl.addr[0], ~dl.addr[0]};
	assign port1_o.data = {dl.dout, dl.dout};

	assign port2_o.addr = spr_addr[23:1];
	assign port2_o.ds   = {spr_addr[0], ~spr_addr[0]};
	assign port2_o.data = {dl.dout, dl.dout};

	assign port_we_o = dl.download;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_last     <= 1'b0;
			port1_req_o <= 1'b0;
			port2_req_o <= 1'b0;
		end else begin
			wr_last <= dl.wr;
			if (wr_rise) begin
				port1_req_o <= ~port1_req_o; // Controller sees the change
				if (dl.addr >= `CORE_SPR_BASE)
					port2_req_o <= ~port2_req_o;
			end
		end
	end

	// Sound CPU strobe comes from its own enable timing
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			snd_vma_r  <= 1'b0;
			snd_vma_r2 <= 1'b0;
			snd_addr_o <= '0;
		end else begin
			snd_vma_r  <= snd_vma_i;
			snd_vma_r2 <= snd_vma_r;
			if (snd_vma_r2)
				snd_addr_o <= {2'b00, snd_rom_addr_i} + `CORE_SND_BASE;
		end
	end

endmodule

/* logic/rom_dl_if.sv */
`timescale 1ns/1ns

interface rom_dl_if;
	logic        download; // High for the whole transfer
	logic [7:0]  index;
	logic        wr;       // Byte valid where this rises
	logic [24:0] addr;
	logic [7:0]  dout;

	modport source (output download, output index, output wr, output addr, output dout);
	modport sink (input download, input index, input wr, input addr, input dout);
endinterface

/* logic/arcade_pkg.sv */
package arcade_pkg;

	// Controls of one player, active high
	typedef struct packed {
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_t;

	// Shared cabinet inputs
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic service;
	} cabinet_t;

	// Bit 0 set means the monitor is turned, so the sticks are rotated
	typedef logic [1:0] orient_t;

	// One SDRAM write port
	typedef struct packed {
		logic [22:0] addr; // Word address
		logic [1:0]  ds;   // Byte select, upper then lower
		logic [15:0] data;
	} sdram_wr_t;

endpackage

/* logic/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Sound CPU ROM base in SDRAM
`define CORE_SND_BASE 18'h20000

// Start of the region that also goes to port 2
`define CORE_SPR_BASE 25'h30000

// Core reset cycles after the last reset cause, short for simulation
`define CORE_RESET_HOLD 16'd64

`endif
